//--- Makefile
# Verilator flow for the instruction cache

VERILATOR ?= verilator
TOP       ?= icache_tb
RTL_TOP   ?= icache
FILELIST  ?= icache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- icache.f
source/icache_pkg.sv
source/icache_way_store.sv
source/icache_replacement.sv
source/icache_refill_ctrl.sv
source/icache.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

//--- sim/icache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module icache_mem_model #(
	parameter int          MAX_STALL = 3,    // longest run of addr_ok low
	parameter int          MAX_DELAY = 6,    // longest reply delay in cycles
	parameter logic [31:0] SEED      = 32'd31
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              jitter,        // random stalls and delays when high
	input  logic              mem_req,
	input  logic [31:0]       mem_read_addr,
	output logic              mem_addr_ok,
	output icache_pkg::word_t mem_read_data,
	output logic              mem_data_ok
);

	import icache_pkg::*;

	logic        addr_ok_q = 1'b0;
	logic        data_ok_q = 1'b0;
	word_t       data_q    = '0;
	logic [31:0] rnd       = SEED;
	int          cycle     = 0;
	int          stall_run = 0;
	logic [31:0] pend_addr [$]; // accepted, not yet answered
	int          pend_due  [$]; // cycle at which each reply may go out

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223; // plain 32-bit lcg
	endfunction

	// rotate by half a word, then scramble, so every address bit shows up
	function automatic word_t word_at(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ 32'hc3a5_0f96;
	endfunction

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			addr_ok_q <= 1'b0;
			data_ok_q <= 1'b0;
			pend_addr.delete(); // drop anything in flight
			pend_due.delete();
			stall_run = 0;
			cycle     = 0;
		end
		else
		begin
			cycle = cycle + 1;
			rnd   = next_rand(rnd);
			if (mem_req && addr_ok_q)
			begin
				pend_addr.push_back(mem_read_addr);
				pend_due.push_back(cycle + (jitter ? int'(rnd[7:4]) % MAX_DELAY + 1 : 1));
			end
			// in order, the head blocks younger replies
			if (pend_addr.size() > 0 && pend_due[0] <= cycle)
			begin
				data_ok_q <= 1'b1;
				data_q    <= word_at(pend_addr.pop_front());
				void'(pend_due.pop_front());
			end
			else
				data_ok_q <= 1'b0;
			if (jitter && rnd[20] && stall_run < MAX_STALL)
			begin
				addr_ok_q <= 1'b0; // back-pressure for one cycle
				stall_run = stall_run + 1;
			end
			else
			begin
				addr_ok_q <= 1'b1;
				stall_run = 0;
			end
		end
	end

	assign mem_addr_ok   = addr_ok_q;
	assign mem_data_ok   = data_ok_q;
	assign mem_read_data = data_q;

endmodule

`default_nettype wire

//--- sim/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

	import icache_pkg::*;

	localparam int NUM_WAYS     = 2;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_STALL    = 3;
	localparam int MAX_DELAY    = 6;
	localparam int NUM_TESTS    = 20;
	// four issues with stalls, last reply delay, queueing, then fill and hit cycles
	localparam int WORST_REFILL = 4 * (MAX_STALL + 1) + MAX_DELAY + 8;
	localparam int CYCLE_LIMIT  = NUM_TESTS * (WORST_REFILL + 2) + 2 * RESET_CYCLES + 50;

	typedef struct packed {
		logic        reset_first; // pulse reset before this entry
		logic        jitter;      // memory stalls and random delays
		fetch_addr_t addr;
		int          fetches;     // expected memory words, 0 or 4
	} test_vec_t;

	logic        clk;
	logic        rst_n;
	logic        cpu_req;
	fetch_addr_t instr_addr;
	logic        cpu_addr_ok;
	logic        cpu_data_ok;
	word_t       instr_rdata;
	logic        mem_req;
	logic [31:0] mem_read_addr;
	word_t       mem_read_data;
	logic        mem_addr_ok;
	logic        mem_data_ok;
	logic        jitter;

	test_vec_t   tests     [NUM_TESTS];
	string       test_name [NUM_TESTS];
	int          n_tests   = 0;
	int          errors    = 0;
	int          passed    = 0;
	int          failed    = 0;
	int          cycles    = 0;
	logic [31:0] fetched [$]; // word addresses taken by memory in the current test

	icache #(
		.NUM_WAYS (NUM_WAYS)
	) i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req       (cpu_req),
		.instr_addr    (instr_addr),
		.cpu_addr_ok   (cpu_addr_ok),
		.cpu_data_ok   (cpu_data_ok),
		.instr_rdata   (instr_rdata),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok)
	);

	icache_mem_model #(
		.MAX_STALL (MAX_STALL),
		.MAX_DELAY (MAX_DELAY),
		.SEED      (32'd31)
	) i_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.jitter        (jitter),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_addr_ok   (mem_addr_ok),
		.mem_read_data (mem_read_data),
		.mem_data_ok   (mem_data_ok)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// memory acceptances and the run limit
	always @(posedge clk)
	begin
		if (rst_n && mem_req && mem_addr_ok)
			fetched.push_back(mem_read_addr);
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the cache gave no answer within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// expected memory word, computed from the word address
	function automatic word_t pattern_word(input fetch_addr_t a);
		logic [31:0] w;
		w = {a[31:2], 2'b00};
		return {w[15:0], w[31:16]} ^ 32'hc3a5_0f96;
	endfunction

	task automatic add_test(input string name, input logic rst, input logic jit,
			input logic [31:0] a, input int f);
		test_name[n_tests]         = name;
		tests[n_tests].reset_first = rst;
		tests[n_tests].jitter      = jit;
		tests[n_tests].addr        = a;
		tests[n_tests].fetches     = f;
		n_tests++;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			$display("ERROR %s: instr_rdata expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_fetches(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("ERROR %s: memory fetches expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_strobe(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERROR %s: cpu_addr_ok expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n   <= 1'b0;
		cpu_req <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// hold the request until cpu_data_ok, then compare
	task automatic run_test(input int t);
		test_vec_t   v;
		word_t       got;
		int          errs_before;
		logic [31:0] line_base;
		logic [31:0] exp_addr;
		v = tests[t];
		errs_before = errors;
		if (v.reset_first)
			apply_reset();
		@(negedge clk);
		fetched.delete();
		@(posedge clk);
		jitter     <= v.jitter;
		cpu_req    <= 1'b1;
		instr_addr <= v.addr;
		@(negedge clk);
		while (!cpu_data_ok)
		begin
			check_strobe(test_name[t], 1'b0, cpu_addr_ok); // nothing accepted while refilling
			@(negedge clk);
		end
		check_strobe(test_name[t], 1'b1, cpu_addr_ok);
		got = instr_rdata;
		@(posedge clk);
		cpu_req <= 1'b0;
		check_word(test_name[t], pattern_word(v.addr), got);
		check_fetches(test_name[t], v.fetches, fetched.size());
		// refill must walk the missed line from word 0 upward
		line_base = {v.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
		for (int n = 0; n < fetched.size(); n++)
		begin
			exp_addr = line_base + 32'(4 * n);
			if (fetched[n] !== exp_addr)
			begin
				$display("ERROR %s: memory read %0d address expected %h, actual %h",
					test_name[t], n, exp_addr, fetched[n]);
				errors++;
			end
		end
		if (errors == errs_before)
		begin
			$display("pass  %s", test_name[t]);
			passed++;
		end
		else
		begin
			$display("fail  %s", test_name[t]);
			failed++;
		end
	endtask

	initial
	begin
		rst_n      = 1'b0;
		cpu_req    = 1'b0;
		instr_addr = '0;
		jitter     = 1'b0;

		// set 3 holds tags 0x000100, 0x000200, 0x000300, later 0x000400
		add_test("cold_miss_w0",      1'b0, 1'b0, 32'h0001_0030, 4);
		add_test("hit_w1",            1'b0, 1'b0, 32'h0001_0034, 0);
		add_test("hit_w2",            1'b0, 1'b0, 32'h0001_0038, 0);
		add_test("hit_w3",            1'b0, 1'b0, 32'h0001_003c, 0);
		add_test("second_tag_miss",   1'b0, 1'b0, 32'h0002_0034, 4);
		add_test("first_tag_hit",     1'b0, 1'b0, 32'h0001_0030, 0);
		add_test("second_tag_hit",    1'b0, 1'b0, 32'h0002_0038, 0);
		add_test("third_tag_evict",   1'b0, 1'b0, 32'h0003_003c, 4); // way 0 goes
		add_test("second_tag_kept",   1'b0, 1'b0, 32'h0002_0030, 0);
		add_test("first_tag_refetch", 1'b0, 1'b0, 32'h0001_0034, 4); // lands in way 1
		add_test("third_tag_hit",     1'b0, 1'b0, 32'h0003_0030, 0);
		add_test("jitter_miss_a",     1'b0, 1'b1, 32'h0abc_de90, 4);
		add_test("jitter_hit_a",      1'b0, 1'b1, 32'h0abc_de94, 0);
		add_test("jitter_miss_b",     1'b0, 1'b1, 32'h1234_5698, 4);
		add_test("jitter_miss_c",     1'b0, 1'b1, 32'h7777_77a4, 4);
		add_test("jitter_hit_b",      1'b0, 1'b1, 32'h1234_569c, 0);
		add_test("jitter_evict",      1'b0, 1'b1, 32'h0004_003c, 4);
		add_test("jitter_hit_a2",     1'b0, 1'b1, 32'h0abc_de9c, 0);
		add_test("reset_refetch",     1'b1, 1'b0, 32'h0001_0030, 4); // reset empties the cache
		add_test("after_reset_hit",   1'b0, 1'b0, 32'h0001_0038, 0);

		repeat (RESET_CYCLES) @(posedge clk); // rst_n is already low from time zero
		rst_n <= 1'b1;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			NUM_TESTS, passed, failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache #(
	parameter int NUM_WAYS = 2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// CPU fetch port
	input  logic                    cpu_req,
	input  icache_pkg::fetch_addr_t instr_addr,  // held until cpu_data_ok
	output logic                    cpu_addr_ok,
	output logic                    cpu_data_ok,
	output icache_pkg::word_t       instr_rdata,
	// memory port, one word per request
	output logic                    mem_req,
	output logic [31:0]             mem_read_addr,
	input  icache_pkg::word_t       mem_read_data,
	input  logic                    mem_addr_ok,
	input  logic                    mem_data_ok
);

	import icache_pkg::*;

	localparam int WAY_W = $clog2(NUM_WAYS);

	logic [TAG_W-1:0]    way_tag   [NUM_WAYS];
	logic [NUM_WAYS-1:0] way_valid;
	line_t               way_line  [NUM_WAYS];
	logic [NUM_WAYS-1:0] hit_vec;   // one hot at most, a tag lives in one way only
	logic                hit;
	logic                miss;
	line_t               hit_line;
	line_fill_t          fill;
	logic                fill_en;
	logic [WAY_W-1:0]    victim;

	genvar w;
	generate
		for (w = 0; w < NUM_WAYS; w++)
		begin : g_way
			icache_way_store i_way (
				.clk      (clk),
				.rst_n    (rst_n),
				.rd_index (instr_addr.index),
				.fill     (fill),
				.fill_en  (fill_en && (victim == WAY_W'(w))), // only the victim way takes it
				.rd_tag   (way_tag[w]),
				.rd_valid (way_valid[w]),
				.rd_line  (way_line[w])
			);

			// tag compare per way
			assign hit_vec[w] = way_valid[w] && (way_tag[w] == instr_addr.tag);
		end
	endgenerate

	// and-or mux over the ways
	always_comb
	begin
		hit_line = '0;
		for (int i = 0; i < NUM_WAYS; i++)
			hit_line = hit_line | (way_line[i] & {$bits(line_t){hit_vec[i]}});
	end

	assign hit         = |hit_vec;
	assign instr_rdata = hit_line[instr_addr.offset]; // word select
	assign miss        = cpu_req && !hit;             // starts a refill when the FSM is idle

	// same cycle answer on a hit
	assign cpu_data_ok = cpu_req && hit;
	assign cpu_addr_ok = cpu_data_ok;

	icache_replacement #(
		.NUM_WAYS (NUM_WAYS)
	) i_replacement (
		.clk       (clk),
		.rst_n     (rst_n),
		.index     (instr_addr.index),
		.fill_done (fill_en),
		.victim    (victim)
	);

	icache_refill_ctrl i_refill_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.miss          (miss),
		.addr          (instr_addr),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_read_data (mem_read_data),
		.mem_addr_ok   (mem_addr_ok),
		.mem_data_ok   (mem_data_ok),
		.fill          (fill),
		.fill_en       (fill_en)
	);

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// address split of a 32-bit fetch address
	localparam int WORD_W   = 32;
	localparam int OFFSET_W = 4;                       // byte offset inside a line
	localparam int INDEX_W  = 4;                       // 16 sets
	localparam int TAG_W    = 32 - INDEX_W - OFFSET_W; // whatever is left, 24

	localparam int WORDS_PER_LINE = 2 ** (OFFSET_W - 2); // four words per line

	typedef logic [WORD_W-1:0] word_t; // one instruction word

	typedef logic [OFFSET_W-3:0] word_sel_t; // word position in a line

	// fields of instr_addr, msb first
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		word_sel_t          offset;   // word inside the line
		logic [1:0]         byte_sel; // ignored, fetches are word aligned
	} fetch_addr_t;

	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

	// miss handling states
	typedef enum logic [1:0] {
		refill_idle,  // waiting for a miss
		refill_issue, // sending word addresses
		refill_drain, // all sent, collecting the rest of the replies
		refill_write  // one cycle, line goes into the victim way
	} refill_state_e;

	// what the refill controller hands to the way stores
	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0]   tag;
		line_t              line;
	} line_fill_t;

endpackage

`default_nettype wire

//--- source/icache_refill_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    miss,          // request present and no way hit
	input  icache_pkg::fetch_addr_t addr,          // held by the CPU during the refill
	output logic                    mem_req,
	output logic [31:0]             mem_read_addr,
	input  icache_pkg::word_t       mem_read_data,
	input  logic                    mem_addr_ok,
	input  logic                    mem_data_ok,
	output icache_pkg::line_fill_t  fill,
	output logic                    fill_en
);

	import icache_pkg::*;

	localparam word_sel_t LAST_WORD = word_sel_t'(WORDS_PER_LINE - 1);

	refill_state_e state_q;
	word_sel_t     issue_cnt;   // next word offset to send
	word_sel_t     ret_cnt;     // next word offset to come back
	line_t         line_q;      // line being assembled
	logic          collecting;  // replies are expected in this state

	assign collecting = (state_q == refill_issue) || (state_q == refill_drain);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q   <= refill_idle;
			issue_cnt <= '0;
			ret_cnt   <= '0;
		end
		else
		begin
			case (state_q)
				refill_idle:
				begin
					if (miss)
					begin
						state_q   <= refill_issue; // mem_req rises next cycle
						issue_cnt <= '0;
						ret_cnt   <= '0;
					end
				end
				refill_issue:
				begin
					if (mem_addr_ok) // an address is taken only while mem_req is high
					begin
						issue_cnt <= issue_cnt + 1'b1;
						if (issue_cnt == LAST_WORD)
							state_q <= refill_drain;
					end
					// early replies can overlap the issue phase
					if (mem_data_ok)
						ret_cnt <= ret_cnt + 1'b1;
				end
				refill_drain:
				begin
					if (mem_data_ok)
					begin
						ret_cnt <= ret_cnt + 1'b1;
						if (ret_cnt == LAST_WORD)
							state_q <= refill_write; // fill strobe one cycle after last word
					end
				end
				refill_write:
					state_q <= refill_idle; // single cycle
				default:
					state_q <= refill_idle;
			endcase
		end
	end

	// replies are in order, so the return count is the word position
	always_ff @(posedge clk)
	begin
		if (collecting && mem_data_ok)
			line_q[ret_cnt] <= mem_read_data;
	end

	assign mem_req = (state_q == refill_issue);
	// counter only moves on acceptance, so the address holds under back-pressure
	assign mem_read_addr = {addr.tag, addr.index, issue_cnt, 2'b00};

	assign fill.index = addr.index;
	assign fill.tag   = addr.tag;
	assign fill.line  = line_q;
	assign fill_en    = (state_q == refill_write);

endmodule

`default_nettype wire

//--- source/icache_replacement.sv
`timescale 1ns/1ns
`default_nettype none

module icache_replacement #(
	parameter int NUM_WAYS = 2
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [icache_pkg::INDEX_W-1:0] index,     // set of the current request
	input  logic                           fill_done, // line fill strobe
	output logic [$clog2(NUM_WAYS)-1:0]    victim
);

	import icache_pkg::*;

	localparam int NUM_SETS = 2 ** INDEX_W;
	localparam int WAY_W    = $clog2(NUM_WAYS);

	logic [WAY_W-1:0] ptr_q [NUM_SETS]; // round robin pointer per set

	// advance after each fill of the set, wrap at the last way
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				ptr_q[s] <= '0;
		end
		else if (fill_done)
		begin
			if (ptr_q[index] == WAY_W'(NUM_WAYS - 1))
				ptr_q[index] <= '0;
			else
				ptr_q[index] <= ptr_q[index] + 1'b1;
		end
	end

	assign victim = ptr_q[index]; // way to overwrite on the next fill

endmodule

`default_nettype wire

//--- source/icache_way_store.sv
`timescale 1ns/1ns
`default_nettype none

module icache_way_store (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [icache_pkg::INDEX_W-1:0] rd_index, // set being looked up
	input  icache_pkg::line_fill_t       fill,
	input  logic                         fill_en,  // already qualified with the way number
	output logic [icache_pkg::TAG_W-1:0] rd_tag,
	output logic                         rd_valid,
	output icache_pkg::line_t            rd_line
);

	import icache_pkg::*;

	localparam int NUM_SETS = 2 ** INDEX_W;

	logic [TAG_W-1:0]    tag_mem  [NUM_SETS]; // one tag per set
	line_t               line_mem [NUM_SETS]; // one line per set
	logic [NUM_SETS-1:0] valid_q;             // cleared by reset, so the cache starts empty

	// valid bits are the only control state in here
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_q <= '0;
		else if (fill_en)
			valid_q[fill.index] <= 1'b1;
	end

	// tag and data are written with the valid bit in the same edge
	always_ff @(posedge clk)
	begin
		if (fill_en)
		begin
			tag_mem[fill.index]  <= fill.tag;
			line_mem[fill.index] <= fill.line; // whole line at once
		end
	end

	// asynchronous read, the lookup happens in the request cycle
	assign rd_tag   = tag_mem[rd_index];
	assign rd_valid = valid_q[rd_index];
	assign rd_line  = line_mem[rd_index];

endmodule

`default_nettype wire
